//--- all.f
design/regReadPkg.sv
design/physRegFile.sv
design/bypassSelect.sv
design/readyScoreboard.sv
design/regReadStage.sv
testbench/tbClock.sv
testbench/regReadAssert.sv
testbench/regReadTb.sv

//--- run.sh
#!/bin/sh
# Build and run the register-read stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module regReadTb -f all.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/VregReadTb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- testbench/regReadTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register-read stage testbench.
// Directed and random stimulus against a
// model of the file and ready map.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module regReadTb
  import regReadPkg::*;
();

  logic clk;
  logic arstN;

  logic      [NUM_LANES-1:0] fuValid;
  physTag_t  [NUM_LANES-1:0] fuSrc1;
  physTag_t  [NUM_LANES-1:0] fuSrc2;
  ckptMask_t [NUM_LANES-1:0] fuMask;
  payload_t  [NUM_LANES-1:0] fuPayload;
  logic      [NUM_LANES-1:0] bypValid;
  physTag_t  [NUM_LANES-1:0] bypDest;
  regData_t  [NUM_LANES-1:0] bypData;
  logic      [NUM_LANES-1:0] unmapValid;
  physTag_t  [NUM_LANES-1:0] unmapTag;
  logic      [NUM_LANES-1:0] wakeValid;
  physTag_t  [NUM_LANES-1:0] wakeTag;
  logic                      ctrlVerified;
  logic                      ctrlMispredict;
  ckptId_t                   ctrlCkpt;
  logic                      recoverFlag;
  logic                      exceptionFlag;

  logic      [NUM_LANES-1:0] fuValidOut;
  payload_t  [NUM_LANES-1:0] fuPayloadOut;
  regData_t  [NUM_LANES-1:0] fuData1Out;
  regData_t  [NUM_LANES-1:0] fuData2Out;
  readyMap_t                 phyRegRdy;

  // Model state, always one step ahead of the last checked cycle.
  regData_t  modelRegs [PHYS_REGS];
  readyMap_t modelRdy;
  int        seed;
  logic      checkEn;

  tbClock uClk (.clk(clk), .arstN_o(arstN));

  regReadStage uut (
    .clk(clk), .arstN_i(arstN),
    .fuValid_i(fuValid), .fuSrc1_i(fuSrc1), .fuSrc2_i(fuSrc2),
    .fuMask_i(fuMask), .fuPayload_i(fuPayload),
    .bypValid_i(bypValid), .bypDest_i(bypDest), .bypData_i(bypData),
    .unmapValid_i(unmapValid), .unmapTag_i(unmapTag),
    .wakeValid_i(wakeValid), .wakeTag_i(wakeTag),
    .ctrlVerified_i(ctrlVerified), .ctrlMispredict_i(ctrlMispredict),
    .ctrlCkpt_i(ctrlCkpt), .recoverFlag_i(recoverFlag),
    .exceptionFlag_i(exceptionFlag),
    .fuValid_o(fuValidOut), .fuPayload_o(fuPayloadOut),
    .fuData1_o(fuData1Out), .fuData2_o(fuData2Out), .phyRegRdy_o(phyRegRdy)
  );

  function automatic readyMap_t archReadyMap();
    readyMap_t m;
    for (int r = 0; r < PHYS_REGS; r++) begin
      m[r] = (r < NUM_ARCH_REGS);
    end
    return m;
  endfunction

  // First matching lane in ascending order wins, else the model file.
  function automatic regData_t expectOperand(input physTag_t tag);
    for (int l = 0; l < NUM_LANES; l++) begin
      if (bypValid[l] && bypDest[l] == tag) return bypData[l];
    end
    return modelRegs[tag];
  endfunction

  function automatic logic expectValid(input int lane);
    logic squash;
    squash = ctrlVerified && ctrlMispredict && fuMask[lane][ctrlCkpt];
    return fuValid[lane] && !squash;
  endfunction

  function automatic physTag_t randTag(input bit narrow);
    physTag_t t;
    t = physTag_t'($random(seed));
    if (narrow) t = t & physTag_t'(15);  // Crowd tags for more hits.
    return t;
  endfunction

  task automatic checkValue(input string sig, input logic [63:0] expVal,
                            input logic [63:0] gotVal);
    assert (gotVal === expVal) else begin
      $display("[FAIL] time %0t %s expected %0h got %0h", $time, sig, expVal, gotVal);
      $display("Simulation FAILED");
      $fatal(1, "Output mismatch.");
    end
  endtask

  task automatic compareOutputs();
    for (int l = 0; l < NUM_LANES; l++) begin
      checkValue($sformatf("fuValid_o[%0d]", l), 64'(expectValid(l)), 64'(fuValidOut[l]));
      checkValue($sformatf("fuPayload_o[%0d]", l), 64'(fuPayload[l]), 64'(fuPayloadOut[l]));
      checkValue($sformatf("fuData1_o[%0d]", l), 64'(expectOperand(fuSrc1[l])),
                 64'(fuData1Out[l]));
      checkValue($sformatf("fuData2_o[%0d]", l), 64'(expectOperand(fuSrc2[l])),
                 64'(fuData2Out[l]));
    end
    checkValue("phyRegRdy_o", 64'(modelRdy), 64'(phyRegRdy));
  endtask

  // What the next rising edge does to the file and the ready map.
  task automatic updateModel();
    if (!recoverFlag) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (bypValid[l]) modelRegs[bypDest[l]] = bypData[l];
      end
    end
    if (exceptionFlag) begin
      modelRdy = archReadyMap();
    end else begin
      for (int l = 0; l < NUM_LANES; l++) begin
        if (unmapValid[l]) modelRdy[unmapTag[l]] = 1'b0;
      end
      for (int l = 0; l < NUM_LANES; l++) begin
        if (wakeValid[l]) modelRdy[wakeTag[l]] = 1'b1;
      end
    end
  endtask

  task automatic clearInputs();
    fuValid        = '0;
    fuSrc1         = '0;
    fuSrc2         = '0;
    fuMask         = '0;
    fuPayload      = '0;
    bypValid       = '0;
    bypDest        = '0;
    bypData        = '0;
    unmapValid     = '0;
    unmapTag       = '0;
    wakeValid      = '0;
    wakeTag        = '0;
    ctrlVerified   = 1'b0;
    ctrlMispredict = 1'b0;
    ctrlCkpt       = '0;
    recoverFlag    = 1'b0;
    exceptionFlag  = 1'b0;
  endtask

  task automatic randomCycle(input bit narrow);
    for (int l = 0; l < NUM_LANES; l++) begin
      fuValid[l]    = 1'($random(seed));
      fuSrc1[l]     = randTag(narrow);
      fuSrc2[l]     = randTag(narrow);
      fuMask[l]     = ckptMask_t'($random(seed));
      fuPayload[l]  = payload_t'($random(seed));
      bypValid[l]   = 1'($random(seed));
      bypDest[l]    = randTag(narrow);
      bypData[l]    = regData_t'($random(seed));
      unmapValid[l] = 1'($random(seed));
      unmapTag[l]   = randTag(narrow);
      wakeValid[l]  = 1'($random(seed));
      wakeTag[l]    = randTag(narrow);
    end
    ctrlVerified   = 1'($random(seed));
    ctrlMispredict = 1'($random(seed));
    ctrlCkpt       = ckptId_t'($random(seed));
    recoverFlag    = (2'($random(seed)) == 2'd0);
    exceptionFlag  = (5'($random(seed)) == 5'd0);
  endtask

  task automatic waitForReset();
    int n;
    n = 0;
    while (arstN !== 1'b1 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (arstN !== 1'b1) begin
      $display("Reset was never released by the clock generator.");
      $display("Simulation FAILED");
      $fatal(1, "Reset timeout.");
    end
  endtask

  // Checks land mid low phase, after the falling-edge drive.
  always begin : compareProc
    @(negedge clk);
    #10;
    if (checkEn) begin
      compareOutputs();
      updateModel();
    end
  end

  initial begin : stimulus
    seed    = 52;
    checkEn = 1'b0;
    clearInputs();
    for (int r = 0; r < PHYS_REGS; r++) modelRegs[r] = '0;
    modelRdy = archReadyMap();
    waitForReset();
    checkEn = 1'b1;

    // Idle reads out of reset.
    repeat (4) begin
      clearInputs();
      for (int l = 0; l < NUM_LANES; l++) begin
        fuValid[l] = 1'b1;
        fuSrc1[l]  = randTag(1'b0);
        fuSrc2[l]  = randTag(1'b0);
      end
      @(negedge clk);
    end

    // Write, read back, then a write blocked by recover.
    clearInputs();
    bypValid[1] = 1'b1;
    bypDest[1]  = 6'd40;
    bypData[1]  = 32'hCAFE_0001;
    @(negedge clk);
    clearInputs();
    fuValid[0] = 1'b1;
    fuSrc1[0]  = 6'd40;
    @(negedge clk);
    clearInputs();
    recoverFlag = 1'b1;
    bypValid[2] = 1'b1;
    bypDest[2]  = 6'd40;
    bypData[2]  = 32'hDEAD_0002;
    fuValid[3]  = 1'b1;
    fuSrc2[3]   = 6'd40;
    @(negedge clk);
    clearInputs();
    fuValid[0] = 1'b1;
    fuSrc2[0]  = 6'd40;
    @(negedge clk);

    // Three lanes hit tag 9, without and with recover.
    for (int rec = 0; rec < 2; rec++) begin
      clearInputs();
      recoverFlag = 1'(rec);
      bypValid    = 4'b1110;
      for (int l = 1; l < NUM_LANES; l++) begin
        bypDest[l] = 6'd9;
        bypData[l] = 32'h0900_0000 + 32'(l) + 32'(rec << 4);
      end
      fuValid   = '1;
      fuSrc1[2] = 6'd9;
      fuSrc2[1] = 6'd9;
      @(negedge clk);
    end
    clearInputs();
    fuValid[3] = 1'b1;
    fuSrc1[3]  = 6'd9;
    @(negedge clk);

    // Squash on checkpoint 3, then a mispredict that is not verified.
    for (int v = 1; v >= 0; v--) begin
      clearInputs();
      fuValid        = '1;
      fuMask[0]      = 8'h08;
      fuMask[1]      = 8'h00;
      fuMask[2]      = 8'hFF;
      fuMask[3]      = 8'h04;
      fuPayload[0]   = 32'h1111_2222;
      fuPayload[2]   = 32'h3333_4444;
      ctrlVerified   = 1'(v);
      ctrlMispredict = 1'b1;
      ctrlCkpt       = 3'd3;
      @(negedge clk);
    end

    // Unmap and wakeup with a tag conflict, then an exception.
    clearInputs();
    unmapValid   = 4'b0011;
    unmapTag[0]  = 6'd2;
    unmapTag[1]  = 6'd5;
    wakeValid[2] = 1'b1;
    wakeTag[2]   = 6'd5;
    wakeValid[3] = 1'b1;
    wakeTag[3]   = 6'd50;
    @(negedge clk);
    clearInputs();
    exceptionFlag = 1'b1;
    unmapValid[0] = 1'b1;
    unmapTag[0]   = 6'd0;
    wakeValid[0]  = 1'b1;
    wakeTag[0]    = 6'd60;
    @(negedge clk);

    for (int i = 0; i < 400; i++) begin
      randomCycle(i[0]);
      @(negedge clk);
    end

    clearInputs();
    @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/regReadAssert.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register-read stage assertions.
// Squash and scoreboard rules, bound
// into the top level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module regReadAssert
  import regReadPkg::*;
(
  input logic                       clk,
  input logic                       arstN_i,
  input logic      [NUM_LANES-1:0]  validIn_i,
  input logic      [NUM_LANES-1:0]  validOut_i,
  input ckptMask_t [NUM_LANES-1:0]  mask_i,
  input logic                       verified_i,
  input logic                       mispredict_i,
  input ckptId_t                    ckpt_i,
  input logic                       exception_i,
  input readyMap_t                  ready_i
);

  // Low NUM_ARCH_REGS bits set.
  localparam readyMap_t ARCH_READY = (readyMap_t'(1) << NUM_ARCH_REGS) - readyMap_t'(1);

  validNeedsInput: assert property (@(posedge clk) disable iff (!arstN_i)
    (validOut_i & ~validIn_i) == '0)
    else $error("An output valid is high without its input valid.");

  for (genvar l = 0; l < NUM_LANES; l++) begin : gSquash
    squashClears: assert property (@(posedge clk) disable iff (!arstN_i)
      (verified_i && mispredict_i && mask_i[l][ckpt_i]) |-> !validOut_i[l])
      else $error("Lane %0d stayed valid under a mispredict squash.", l);
  end

  exceptionRestores: assert property (@(posedge clk) disable iff (!arstN_i)
    exception_i |=> (ready_i == ARCH_READY))
    else $error("Ready map did not return to its reset pattern after an exception.");

endmodule

bind regReadStage regReadAssert uChecks (
  .clk          (clk),
  .arstN_i      (arstN_i),
  .validIn_i    (fuValid_i),
  .validOut_i   (fuValid_o),
  .mask_i       (fuMask_i),
  .verified_i   (ctrlVerified_i),
  .mispredict_i (ctrlMispredict_i),
  .ckpt_i       (ctrlCkpt_i),
  .exception_i  (exceptionFlag_i),
  .ready_i      (phyRegRdy_o)
);

`default_nettype wire

//--- testbench/tbClock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset generator.
// 40 ns clock, reset low for 3 cycles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic clk,
  output logic arstN_o
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    arstN_o = 1'b0;
    repeat (3) @(posedge clk);
    #5;
    arstN_o = 1'b1;  // Released between edges.
  end

endmodule

`default_nettype wire

//--- design/regReadStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register-read stage, four lanes wide.
// Reads operands from the file or the
// bypass, squashes wrong-path work and
// keeps the ready scoreboard.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module regReadStage
  import regReadPkg::*;
(
  input  logic                       clk,
  input  logic                       arstN_i,

  // Issue lanes.
  input  logic      [NUM_LANES-1:0]  fuValid_i,
  input  physTag_t  [NUM_LANES-1:0]  fuSrc1_i,
  input  physTag_t  [NUM_LANES-1:0]  fuSrc2_i,
  input  ckptMask_t [NUM_LANES-1:0]  fuMask_i,
  input  payload_t  [NUM_LANES-1:0]  fuPayload_i,

  // Writeback bypass lanes.
  input  logic      [NUM_LANES-1:0]  bypValid_i,
  input  physTag_t  [NUM_LANES-1:0]  bypDest_i,
  input  regData_t  [NUM_LANES-1:0]  bypData_i,

  // Scoreboard updates.
  input  logic      [NUM_LANES-1:0]  unmapValid_i,
  input  physTag_t  [NUM_LANES-1:0]  unmapTag_i,
  input  logic      [NUM_LANES-1:0]  wakeValid_i,
  input  physTag_t  [NUM_LANES-1:0]  wakeTag_i,

  // Branch resolution.
  input  logic                       ctrlVerified_i,
  input  logic                       ctrlMispredict_i,
  input  ckptId_t                    ctrlCkpt_i,

  input  logic                       recoverFlag_i,
  input  logic                       exceptionFlag_i,

  // To the functional units.
  output logic      [NUM_LANES-1:0]  fuValid_o,
  output payload_t  [NUM_LANES-1:0]  fuPayload_o,
  output regData_t  [NUM_LANES-1:0]  fuData1_o,
  output regData_t  [NUM_LANES-1:0]  fuData2_o,

  output readyMap_t                  phyRegRdy_o
);

  physTag_t [NUM_RD_PORTS-1:0] srcTag;
  regData_t [NUM_RD_PORTS-1:0] fileData;
  regData_t [NUM_RD_PORTS-1:0] opData;
  logic     [NUM_LANES-1:0]    wrEn;
  logic                        mispredict;

  // Port 2i is source 1 of lane i, port 2i+1 is source 2.
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      srcTag[2*l]   = fuSrc1_i[l];
      srcTag[2*l+1] = fuSrc2_i[l];
    end
  end

  // No file writes while recovering. Forwarding still works.
  assign wrEn = bypValid_i & {NUM_LANES{~recoverFlag_i}};

  physRegFile uPrf (
    .clk      (clk),
    .arstN_i  (arstN_i),
    .rdTag_i  (srcTag),
    .rdData_o (fileData),
    .wrEn_i   (wrEn),
    .wrTag_i  (bypDest_i),
    .wrData_i (bypData_i)
  );

  bypassSelect uByp (
    .srcTag_i   (srcTag),
    .fileData_i (fileData),
    .bypValid_i (bypValid_i),
    .bypDest_i  (bypDest_i),
    .bypData_i  (bypData_i),
    .opData_o   (opData)
  );

  readyScoreboard uRdy (
    .clk             (clk),
    .arstN_i         (arstN_i),
    .exceptionFlag_i (exceptionFlag_i),
    .unmapValid_i    (unmapValid_i),
    .unmapTag_i      (unmapTag_i),
    .wakeValid_i     (wakeValid_i),
    .wakeTag_i       (wakeTag_i),
    .phyRegRdy_o     (phyRegRdy_o)
  );

  assign mispredict = ctrlVerified_i & ctrlMispredict_i;

  // Kill lanes that depend on the mispredicted checkpoint.
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      fuValid_o[l]   = fuValid_i[l] & ~(mispredict & fuMask_i[l][ctrlCkpt_i]);
      fuPayload_o[l] = fuPayload_i[l];
      fuData1_o[l]   = opData[2*l];
      fuData2_o[l]   = opData[2*l+1];
    end
  end

endmodule

`default_nettype wire

//--- design/readyScoreboard.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Physical register ready scoreboard.
// One bit per register, cleared on unmap,
// set on wakeup, restored on exception.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module readyScoreboard
  import regReadPkg::*;
(
  input  logic                      clk,
  input  logic                      arstN_i,
  input  logic                      exceptionFlag_i,

  input  logic     [NUM_LANES-1:0]  unmapValid_i,
  input  physTag_t [NUM_LANES-1:0]  unmapTag_i,

  input  logic     [NUM_LANES-1:0]  wakeValid_i,
  input  physTag_t [NUM_LANES-1:0]  wakeTag_i,

  output readyMap_t                 phyRegRdy_o
);

  readyMap_t rdyQ;
  readyMap_t rdyNext;

  // Clears first, then sets.
  // A wakeup beats an unmap of the same tag.
  always_comb begin
    rdyNext = rdyQ;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (unmapValid_i[l]) begin
        rdyNext[unmapTag_i[l]] = 1'b0;
      end
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      if (wakeValid_i[l]) begin
        rdyNext[wakeTag_i[l]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      rdyQ <= READY_RESET;
    end else if (exceptionFlag_i) begin
      rdyQ <= READY_RESET;  // Back to the architectural map.
    end else begin
      rdyQ <= rdyNext;
    end
  end

  assign phyRegRdy_o = rdyQ;

endmodule

`default_nettype wire

//--- design/bypassSelect.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand bypass select.
// Matches every source tag against the
// writeback lanes and picks the operand.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module bypassSelect
  import regReadPkg::*;
(
  // One entry per read port.
  input  physTag_t [NUM_RD_PORTS-1:0]  srcTag_i,
  input  regData_t [NUM_RD_PORTS-1:0]  fileData_i,

  // Writeback lanes of this cycle.
  input  logic     [NUM_LANES-1:0]     bypValid_i,
  input  physTag_t [NUM_LANES-1:0]     bypDest_i,
  input  regData_t [NUM_LANES-1:0]     bypData_i,

  output regData_t [NUM_RD_PORTS-1:0]  opData_o
);

  // Hit matrix, one row per read port.
  logic [NUM_RD_PORTS-1:0][NUM_LANES-1:0] hit;

  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        hit[p][l] = bypValid_i[l] && (srcTag_i[p] == bypDest_i[l]);
      end
    end
  end

  // Walk lanes from high to low so the lowest hit is assigned last.
  // No hit falls back to the file value.
  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      opData_o[p] = fileData_i[p];
      for (int l = NUM_LANES - 1; l >= 0; l--) begin
        if (hit[p][l]) begin
          opData_o[p] = bypData_i[l];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/physRegFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Physical register file.
// Eight asynchronous read ports, four
// clocked write ports.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module physRegFile
  import regReadPkg::*;
(
  input  logic                               clk,
  input  logic                               arstN_i,

  // Read side, ordered lane 0 src 1, lane 0 src 2, ...
  input  physTag_t [NUM_RD_PORTS-1:0]        rdTag_i,
  output regData_t [NUM_RD_PORTS-1:0]        rdData_o,

  // Write side, one port per bypass lane.
  input  logic     [NUM_LANES-1:0]           wrEn_i,
  input  physTag_t [NUM_LANES-1:0]           wrTag_i,
  input  regData_t [NUM_LANES-1:0]           wrData_i
);

  regData_t regs [PHYS_REGS];

  // Writes land at the edge. Later lanes override earlier ones on
  // a tag collision, so the highest lane wins.
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      for (int r = 0; r < PHYS_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int w = 0; w < NUM_LANES; w++) begin
        if (wrEn_i[w]) begin
          regs[wrTag_i[w]] <= wrData_i[w];
        end
      end
    end
  end

  // Combinational reads.
  // Same-cycle writes are not visible here.
  always_comb begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      rdData_o[p] = regs[rdTag_i[p]];
    end
  end

endmodule

`default_nettype wire

//--- design/regReadPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register-read stage package.
// Sizes and shared types for the
// register file, bypass and scoreboard.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package regReadPkg;

  // Machine width.
  localparam int NUM_LANES    = 4;
  localparam int NUM_RD_PORTS = 2 * NUM_LANES;  // Two sources per lane.

  // Physical register file.
  localparam int PHYS_REGS  = 64;
  localparam int PHYS_TAG_W = $clog2(PHYS_REGS);
  localparam int DATA_W     = 32;

  // Branch checkpoints.
  localparam int NUM_CKPTS = 8;
  localparam int CKPT_ID_W = $clog2(NUM_CKPTS);

  // Architectural registers are mapped and ready out of reset.
  localparam int NUM_ARCH_REGS = 34;

  localparam int PAYLOAD_W = 32;

  typedef logic [PHYS_TAG_W-1:0] physTag_t;
  typedef logic [DATA_W-1:0]     regData_t;
  typedef logic [NUM_CKPTS-1:0]  ckptMask_t;
  typedef logic [CKPT_ID_W-1:0]  ckptId_t;
  typedef logic [PAYLOAD_W-1:0]  payload_t;  // Opaque issue fields.
  typedef logic [PHYS_REGS-1:0]  readyMap_t;

  // Low registers ready, the free pool not ready.
  localparam readyMap_t READY_RESET = readyMap_t'({NUM_ARCH_REGS{1'b1}});

endpackage

`default_nettype wire
